// ==== fifo_macros.svh ====
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// Word width in bits.
`define FIFO_DATA_WIDTH 8

// Number of words, power of two only.
`define FIFO_DEPTH 16
`define FIFO_ADDR_WIDTH 4

// Flag thresholds as fill levels.
`define FIFO_AFULL_LVL (`FIFO_DEPTH - 2)
`define FIFO_AEMPTY_LVL 2

`endif

// ==== fifo_data_pkg.sv ====
package fifo_data_pkg;

`include "fifo_macros.svh"

  typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_word_t;

  // RAM write port bundle.
  typedef struct packed {
    logic                        en;
    logic [`FIFO_ADDR_WIDTH-1:0] addr;
    fifo_word_t                  data;
  } ram_wr_req_t;

  // RAM read port bundle.
  typedef struct packed {
    logic                        en;
    logic [`FIFO_ADDR_WIDTH-1:0] addr;
  } ram_rd_req_t;

endpackage

// ==== fifo_ctrl_pkg.sv ====
package fifo_ctrl_pkg;

`include "fifo_macros.svh"

  // Top bit flags a wrapped pointer.
  typedef logic [`FIFO_ADDR_WIDTH:0] fifo_ptr_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  function automatic fifo_ptr_t bin2gray(input fifo_ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  function automatic fifo_ptr_t gray2bin(input fifo_ptr_t gray);
    fifo_ptr_t bin;
    bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== gray_ptr_sync.sv ====
`timescale 1ns/100ps

module gray_ptr_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fifo_ctrl_pkg::fifo_ptr_t gray_in,
  output fifo_ctrl_pkg::fifo_ptr_t gray_out
);

  // **********************************************************************
  // Flop chain, first stage may go metastable.
  // **********************************************************************
  fifo_ctrl_pkg::fifo_ptr_t sync_q [SYNC_STAGES];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= gray_in;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign gray_out = sync_q[SYNC_STAGES-1]; // Last stage is stable.

endmodule

// ==== fifo_wr_ctrl.sv ====
`timescale 1ns/100ps

`include "fifo_macros.svh"

module fifo_wr_ctrl
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  logic        wr_clk,
  input  logic        wr_rst_n,
  input  logic        wr_en,
  input  fifo_word_t  wr_data,
  input  fifo_ptr_t   rd_gray_sync,
  output fifo_ptr_t   wr_gray,
  output ram_wr_req_t ram_wr,
  output wr_status_t  wr_status
);

  logic      wr_vld;
  fifo_ptr_t wr_bin;
  fifo_ptr_t wr_bin_nxt;
  fifo_ptr_t rd_bin_sync;
  fifo_ptr_t used_nxt;

  // **********************************************************************
  // Write pointer.
  // **********************************************************************
  assign wr_vld     = wr_en & ~wr_status.full; // Drop writes when full.
  assign wr_bin_nxt = wr_bin + fifo_ptr_t'(wr_vld);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= bin2gray(wr_bin_nxt); // Registered before crossing.
    end
  end

  // RAM write request.
  assign ram_wr.en   = wr_vld;
  assign ram_wr.addr = wr_bin[`FIFO_ADDR_WIDTH-1:0];
  assign ram_wr.data = wr_data;

  // **********************************************************************
  // Flags from next pointer and lagging read pointer.
  // **********************************************************************
  assign rd_bin_sync = gray2bin(rd_gray_sync);
  assign used_nxt    = wr_bin_nxt - rd_bin_sync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status.full  <= 1'b0;
      wr_status.afull <= 1'b0;
    end else begin
      wr_status.full  <= (used_nxt == fifo_ptr_t'(`FIFO_DEPTH));
      wr_status.afull <= (used_nxt >= fifo_ptr_t'(`FIFO_AFULL_LVL));
    end
  end

endmodule

// ==== fifo_rd_ctrl.sv ====
`timescale 1ns/100ps

`include "fifo_macros.svh"

module fifo_rd_ctrl
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  logic        rd_clk,
  input  logic        rd_rst_n,
  input  logic        rd_en,
  input  fifo_ptr_t   wr_gray_sync,
  output fifo_ptr_t   rd_gray,
  output ram_rd_req_t ram_rd,
  output rd_status_t  rd_status
);

  logic      rd_vld;
  fifo_ptr_t rd_bin;
  fifo_ptr_t rd_bin_nxt;
  fifo_ptr_t rd_gray_nxt;
  fifo_ptr_t wr_bin_sync;
  fifo_ptr_t fill_nxt;

  // **********************************************************************
  // Read pointer.
  // **********************************************************************
  assign rd_vld      = rd_en & ~rd_status.empty; // Ignore reads when empty.
  assign rd_bin_nxt  = rd_bin + fifo_ptr_t'(rd_vld);
  assign rd_gray_nxt = bin2gray(rd_bin_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // RAM read request, data lands on this same edge.
  assign ram_rd.en   = rd_vld;
  assign ram_rd.addr = rd_bin[`FIFO_ADDR_WIDTH-1:0];

  // **********************************************************************
  // Flags from next pointer and lagging write pointer.
  // **********************************************************************
  assign wr_bin_sync = gray2bin(wr_gray_sync);
  assign fill_nxt    = wr_bin_sync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
    end else begin
      rd_status.empty  <= (rd_gray_nxt == wr_gray_sync); // Gray compare.
      rd_status.aempty <= (fill_nxt <= fifo_ptr_t'(`FIFO_AEMPTY_LVL));
    end
  end

endmodule

// ==== dualport_ram_async.sv ====
`timescale 1ns/100ps

`include "fifo_macros.svh"

module dualport_ram_async
  import fifo_data_pkg::*;
(
  input  logic        wr_clk,
  input  ram_wr_req_t ram_wr,
  input  logic        rd_clk,
  input  logic        rd_rst_n,
  input  ram_rd_req_t ram_rd,
  output fifo_word_t  rd_data
);

  // **********************************************************************
  // Storage array.
  // **********************************************************************
  fifo_word_t mem [`FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (ram_wr.en) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // **********************************************************************
  // Registered read port.
  // **********************************************************************
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (ram_rd.en) begin
      rd_data <= mem[ram_rd.addr]; // Holds between reads.
    end
  end

endmodule

// ==== async_fifo.sv ====
`timescale 1ns/100ps

module async_fifo
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  fifo_word_t wr_data,
  output wr_status_t wr_status,
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  output fifo_word_t rd_data,
  output rd_status_t rd_status
);

  ram_wr_req_t ram_wr;
  ram_rd_req_t ram_rd;
  fifo_ptr_t   wr_gray;
  fifo_ptr_t   wr_gray_sync;
  fifo_ptr_t   rd_gray;
  fifo_ptr_t   rd_gray_sync;

  // **********************************************************************
  // Write domain.
  // **********************************************************************
  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .rd_gray_sync (rd_gray_sync),
    .wr_gray      (wr_gray),
    .ram_wr       (ram_wr),
    .wr_status    (wr_status)
  );

  gray_ptr_sync rd2wr_sync (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

  // **********************************************************************
  // Read domain.
  // **********************************************************************
  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .rd_gray      (rd_gray),
    .ram_rd       (ram_rd),
    .rd_status    (rd_status)
  );

  gray_ptr_sync wr2rd_sync (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

  dualport_ram_async u_ram (
    .wr_clk   (wr_clk),
    .ram_wr   (ram_wr),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .ram_rd   (ram_rd),
    .rd_data  (rd_data)
  );

endmodule

// ==== async_fifo_checker.sv ====
`timescale 1ns/100ps

module async_fifo_checker
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input logic       wr_clk,
  input logic       wr_rst_n,
  input logic       rd_clk,
  input logic       rd_rst_n,
  input wr_status_t wr_status,
  input rd_status_t rd_status,
  input fifo_word_t rd_data
);

  int unsigned fail_count = 0; // Read by the testbench at the end.

  // **********************************************************************
  // Flag relations.
  // **********************************************************************
  full_implies_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_status.full |-> wr_status.afull)
    else begin
      $error("full set without afull");
      fail_count++;
    end

  empty_implies_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |-> rd_status.aempty)
    else begin
      $error("empty set without aempty");
      fail_count++;
    end

  never_full_and_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !(wr_status.full && rd_status.empty))
    else begin
      $error("full and empty both high");
      fail_count++;
    end

  // Output register only loads on an accepted read.
  data_stable_when_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |=> $stable(rd_data))
    else begin
      $error("rd_data changed while empty");
      fail_count++;
    end

  // **********************************************************************
  // No X on the flags.
  // **********************************************************************
  wr_flags_known: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !$isunknown(wr_status))
    else begin
      $error("wr_status unknown");
      fail_count++;
    end

  rd_flags_known: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !$isunknown(rd_status))
    else begin
      $error("rd_status unknown");
      fail_count++;
    end

endmodule

bind async_fifo async_fifo_checker chk0 (
  .wr_clk    (wr_clk),
  .wr_rst_n  (wr_rst_n),
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .wr_status (wr_status),
  .rd_status (rd_status),
  .rd_data   (rd_data)
);

// ==== async_fifo_tb.sv ====
`timescale 1ns/100ps

`include "fifo_macros.svh"

module async_fifo_tb
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
();

  localparam int DRIVE_DLY      = 10;
  localparam int RAND_OPS       = 400;
  localparam int TIMEOUT_CYCLES = 3000; // Twice the summed test lengths.

  logic        wr_clk;
  logic        wr_rst_n;
  logic        wr_en;
  fifo_word_t  wr_data;
  wr_status_t  wr_status;
  logic        rd_clk;
  logic        rd_rst_n;
  logic        rd_en;
  fifo_word_t  rd_data;
  rd_status_t  rd_status;

  fifo_word_t  model [$]; // Words the FIFO holds.
  logic [31:0] lcg_state = 32'd59359;
  int          err_count = 0;
  int          test_err_start = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          rd_cycles = 0;

  async_fifo dut0 (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .wr_status (wr_status),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .rd_status (rd_status)
  );

  // **********************************************************************
  // Clocks and watchdog.
  // **********************************************************************
  initial begin
    rd_clk = 1'b0;
    forever #50 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #35 wr_clk = ~wr_clk;
  end

  initial begin
    while (rd_cycles < TIMEOUT_CYCLES) begin
      @(posedge rd_clk);
      rd_cycles++;
    end
    $display("ERROR: timeout, tests did not finish in %0d rd_clk cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // **********************************************************************
  // Helpers.
  // **********************************************************************
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic wr_status_t exp_wr_status(input int count);
    wr_status_t s;
    s.full  = (count == `FIFO_DEPTH);
    s.afull = (count >= `FIFO_AFULL_LVL);
    return s;
  endfunction

  function automatic rd_status_t exp_rd_status(input int count);
    rd_status_t s;
    s.empty  = (count == 0);
    s.aempty = (count <= `FIFO_AEMPTY_LVL);
    return s;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic compare_word(input string name, input fifo_word_t exp, input fifo_word_t act);
    if (act !== exp) begin
      $display("FAIL %0t ns %s expected %h actual %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic compare_wr_status(input wr_status_t exp, input wr_status_t act);
    if (act !== exp) begin
      $display("FAIL %0t ns wr_status expected %b actual %b", $time, exp, act);
      err_count++;
    end
  endtask

  task automatic compare_rd_status(input rd_status_t exp, input rd_status_t act);
    if (act !== exp) begin
      $display("FAIL %0t ns rd_status expected %b actual %b", $time, exp, act);
      err_count++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_count == test_err_start) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, err_count - test_err_start);
    end
    test_err_start = err_count;
  endtask

  // One write attempt, pushed to the model if full was low.
  task automatic write_word(input fifo_word_t data, output bit accepted);
    @(posedge wr_clk);
    #DRIVE_DLY;
    accepted = !wr_status.full;
    wr_en    = 1'b1;
    wr_data  = data;
    if (accepted) model.push_back(data);
    @(posedge wr_clk);
    #DRIVE_DLY;
    wr_en = 1'b0;
  endtask

  // One read attempt, data is checked after the accepting edge.
  task automatic read_word(output bit accepted);
    fifo_word_t exp;
    @(posedge rd_clk);
    #DRIVE_DLY;
    accepted = !rd_status.empty;
    rd_en    = 1'b1;
    @(posedge rd_clk);
    #DRIVE_DLY;
    rd_en = 1'b0;
    if (accepted) begin
      if (model.size() == 0) begin
        report_error("read accepted while the model holds no word");
      end else begin
        exp = model.pop_front();
        compare_word("rd_data", exp, rd_data);
      end
    end
  endtask

  task automatic settle();
    repeat (5) @(posedge wr_clk);
    repeat (5) @(posedge rd_clk);
    #DRIVE_DLY;
  endtask

  task automatic check_flags(input int count);
    compare_wr_status(exp_wr_status(count), wr_status);
    compare_rd_status(exp_rd_status(count), rd_status);
  endtask

  task automatic drain();
    bit acc;
    while (model.size() > 0) begin
      read_word(acc);
    end
    settle();
    check_flags(0);
  endtask

  // **********************************************************************
  // Tests.
  // **********************************************************************
  task automatic test_reset();
    check_flags(0);
    compare_word("rd_data", '0, rd_data);
    end_test("reset");
  endtask

  task automatic test_order();
    bit          acc;
    logic [31:0] r;
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      write_word(r[23:16], acc);
      repeat (r[5:4]) @(posedge wr_clk); // Idle gap.
    end
    drain();
    end_test("order");
  endtask

  task automatic test_overflow();
    bit acc;
    for (int i = 0; i < `FIFO_DEPTH + 3; i++) begin
      write_word(fifo_word_t'(8'h40 + i), acc);
    end
    settle();
    check_flags(model.size());
    if (model.size() != `FIFO_DEPTH) report_error("writes while full were not dropped");
    drain();
    end_test("overflow");
  endtask

  task automatic test_levels();
    bit          acc;
    logic [31:0] r;
    for (int lvl = 0; lvl <= `FIFO_DEPTH; lvl++) begin
      settle();
      if (model.size() != lvl) report_error("fill level differs from the written count");
      check_flags(lvl);
      if (lvl < `FIFO_DEPTH) begin
        r = next_rand();
        write_word(r[23:16], acc);
      end
    end
    drain();
    end_test("levels");
  endtask

  task automatic test_empty_read();
    bit         acc;
    fifo_word_t held;
    settle();
    held = rd_data;
    repeat (4) begin
      read_word(acc);
      if (acc) report_error("read accepted while the FIFO was empty");
    end
    compare_word("rd_data", held, rd_data);
    compare_rd_status(exp_rd_status(0), rd_status);
    end_test("empty_read");
  endtask

  task automatic test_random();
    bit          acc;
    logic [31:0] r;
    for (int i = 0; i < RAND_OPS; i++) begin
      r = next_rand();
      if (r[16]) write_word(r[31:24], acc);
      else read_word(acc);
      repeat (r[9:8]) @(posedge rd_clk);
    end
    settle();
    check_flags(model.size());
    drain();
    end_test("random");
  endtask

  initial begin
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    repeat (5) @(posedge rd_clk);
    #DRIVE_DLY;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    test_reset();
    test_order();
    test_overflow();
    test_levels();
    test_empty_read();
    test_random();
    if (dut0.chk0.fail_count != 0) begin
      $display("ERROR: %0d assertion failures in the checker", dut0.chk0.fail_count);
      err_count += dut0.chk0.fail_count;
    end
    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== async_fifo_sys.f ====
+incdir+.
fifo_data_pkg.sv
fifo_ctrl_pkg.sv
gray_ptr_sync.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
dualport_ram_async.sv
async_fifo.sv
async_fifo_checker.sv
async_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: async_fifo_sys

sources:
  - include_dirs:
      - .
    files:
      - fifo_data_pkg.sv
      - fifo_ctrl_pkg.sv
      - gray_ptr_sync.sv
      - fifo_wr_ctrl.sv
      - fifo_rd_ctrl.sv
      - dualport_ram_async.sv
      - async_fifo.sv
      - target: test
        files:
          - async_fifo_checker.sv
          - async_fifo_tb.sv
